// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    localparam int xlen     = 32;   // PC and instruction width
    localparam int credit_w = 4;    // Enough for fb_depth up to 15

    typedef logic [xlen-1:0]     t_pc;        // Byte address, always word-aligned
    typedef logic [xlen-1:0]     t_rv_instr;  // Raw RV32 instruction word
    typedef logic [15:0]         t_simid;     // Counts packets taken by decode
    typedef logic [1:0]          t_epoch;     // Redirect generation
    typedef logic [credit_w-1:0] t_credit;

    // Fetch buffer to instruction memory
    typedef struct packed {
        logic   valid;
        t_pc    pc;
        t_epoch epoch;
    } t_mem_req_pkt;

    // Memory answer, request fields echoed back
    typedef struct packed {
        logic      valid;
        t_pc       pc;
        t_epoch    epoch;
        t_rv_instr instr;
    } t_mem_rsp_pkt;

    // Fetch control to fetch buffer
    typedef struct packed {
        logic   valid;   // Request a fetch at pc
        t_pc    pc;
        t_epoch epoch;   // Tag carried to memory and back
        logic   flush;   // Redirect, drop queue contents
    } t_fe_fb_req;

    // Fetch buffer status back to control
    typedef struct packed {
        logic      head_valid;
        t_pc       head_pc;
        t_rv_instr head_instr;
        t_credit   free_credit;   // Free slots minus requests in flight
    } t_fb_fe_rsp;

    // Packet handed to decode
    typedef struct packed {
        t_pc       pc;
        t_rv_instr instr;
        t_simid    simid;
    } t_instr_pkt;

    // Mispredict from execute
    typedef struct packed {
        logic valid;
        t_pc  target;
    } t_br_mispred_pkt;

    // Nuke from retire, fetch restarts at pc after resume
    typedef struct packed {
        logic valid;
        t_pc  pc;
    } t_nuke_pkt;

endpackage

// ==== source/instr_rom.sv ====
`timescale 1ns/1ns

module instr_rom
    import fetch_pkg::*;
#(
    parameter int rom_words   = 128,   // Power of two, index wraps
    parameter int rom_latency = 2      // At least one
) (
    input  logic         clk,
    input  logic         arst_n,

    input  t_mem_req_pkt req,
    output t_mem_rsp_pkt rsp,

    input  logic         load_en,      // Program load, fetch idle
    input  t_pc          load_addr,
    input  t_rv_instr    load_data
);

    localparam int idx_w = $clog2(rom_words);

    t_rv_instr              rom [rom_words];
    logic [idx_w-1:0]       rd_idx;
    logic [idx_w-1:0]       wr_idx;

    logic [rom_latency-1:0] vld_q;               // Valid delay line
    t_pc                    pc_q    [rom_latency];
    t_epoch                 epoch_q [rom_latency];
    t_rv_instr              instr_q [rom_latency];

    assign rd_idx = req.pc[idx_w+1:2];      // Word index
    assign wr_idx = load_addr[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (load_en)
            rom[wr_idx] <= load_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= req.valid;
            for (int i = 1; i < rom_latency; i++)
                vld_q[i] <= vld_q[i-1];
        end
    end

    // Data read at request time, then delayed
    always_ff @(posedge clk) begin
        pc_q[0]    <= req.pc;
        epoch_q[0] <= req.epoch;
        instr_q[0] <= rom[rd_idx];
        for (int i = 1; i < rom_latency; i++) begin
            pc_q[i]    <= pc_q[i-1];
            epoch_q[i] <= epoch_q[i-1];
            instr_q[i] <= instr_q[i-1];
        end
    end

    assign rsp = '{valid: vld_q[rom_latency-1],
                   pc:    pc_q[rom_latency-1],
                   epoch: epoch_q[rom_latency-1],
                   instr: instr_q[rom_latency-1]};

    // Fetch never sends a misaligned address
    a_req_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        req.valid |-> req.pc[1:0] == 2'b00);

endmodule

// ==== source/fe_buf.sv ====
`timescale 1ns/1ns

module fe_buf
    import fetch_pkg::*;
#(
    parameter int fb_depth = 4   // Must fit in t_credit
) (
    input  logic         clk,
    input  logic         arst_n,

    input  t_fe_fb_req   fe_fb_req_fb0,
    output t_fb_fe_rsp   fb_fe_rsp_nnn,
    input  logic         pop,

    output t_mem_req_pkt fb_ic_req_nnn,
    input  t_mem_rsp_pkt ic_fb_rsp_nnn
);

    localparam int cnt_w = $clog2(fb_depth + 1);
    localparam int ptr_w = (fb_depth > 1) ? $clog2(fb_depth) : 1;

    t_pc                q_pc    [fb_depth];   // Queue payload
    t_rv_instr          q_instr [fb_depth];

    logic [ptr_w-1:0]   wr_ptr_q;
    logic [ptr_w-1:0]   rd_ptr_q;
    logic [cnt_w-1:0]   count_q;      // Words in the queue
    logic [cnt_w-1:0]   out_q;        // Requests in flight, any epoch
    t_epoch             epoch_q;

    logic               flush;
    logic               stale;
    logic               push;
    logic               do_pop;

    assign flush  = fe_fb_req_fb0.flush;
    assign stale  = ic_fb_rsp_nnn.epoch != epoch_q;
    assign push   = ic_fb_rsp_nnn.valid && !stale && !flush;   // Flush drops it too
    assign do_pop = pop && !flush;

    // Straight to memory, it never refuses
    assign fb_ic_req_nnn = '{valid: fe_fb_req_fb0.valid,
                             pc:    fe_fb_req_fb0.pc,
                             epoch: fe_fb_req_fb0.epoch};

    always_comb begin
        fb_fe_rsp_nnn.head_valid  = count_q != '0;
        fb_fe_rsp_nnn.head_pc     = q_pc[rd_ptr_q];
        fb_fe_rsp_nnn.head_instr  = q_instr[rd_ptr_q];
        fb_fe_rsp_nnn.free_credit = t_credit'(fb_depth - int'(count_q) - int'(out_q));
    end

    // In-flight count, stale returns still release their credit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out_q <= '0;
        else
            out_q <= out_q + cnt_w'(fb_ic_req_nnn.valid) - cnt_w'(ic_fb_rsp_nnn.valid);
    end

    // Queue pointers and epoch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            epoch_q  <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;            // Empty in one cycle
            rd_ptr_q <= '0;
            count_q  <= '0;
            epoch_q  <= epoch_q + t_epoch'(1);
        end else begin
            if (push)
                wr_ptr_q <= (wr_ptr_q == ptr_w'(fb_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= (rd_ptr_q == ptr_w'(fb_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + cnt_w'(push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[wr_ptr_q]    <= ic_fb_rsp_nnn.pc;
            q_instr[wr_ptr_q] <= ic_fb_rsp_nnn.instr;
        end
    end

    // Credit in fe_ctl keeps the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count_q < cnt_w'(fb_depth));

    a_out_bound: assert property (@(posedge clk) disable iff (!arst_n)
        out_q <= cnt_w'(fb_depth));

    // fe_ctl and this block advance their epochs on the same edges
    a_epoch_sync: assert property (@(posedge clk) disable iff (!arst_n)
        fe_fb_req_fb0.valid |-> fe_fb_req_fb0.epoch == epoch_q);

endmodule

// ==== source/fe_ctl.sv ====
`timescale 1ns/1ns

module fe_ctl
    import fetch_pkg::*;
#(
    parameter t_pc reset_pc = '0
) (
    input  logic            clk,
    input  logic            arst_n,

    input  t_nuke_pkt       nuke_rb1,
    input  logic            resume_fetch_rbx,
    input  t_br_mispred_pkt br_mispred_ex0,

    output t_fe_fb_req      fe_fb_req_nnn,
    input  t_fb_fe_rsp      fb_fe_rsp_nnn,

    input  logic            stall,
    output logic            valid_fe1,
    output t_instr_pkt      instr_fe1
);

    logic   redirect;     // Any redirect this cycle
    t_pc    redirect_pc;
    logic   issue;        // Fetch request goes out
    logic   accept;       // Decode takes fe1
    logic   load;         // fe1 takes the queue head

    t_pc    pc_q;         // Next fetch address
    t_epoch epoch_q;
    logic   halted_q;     // Set by nuke, cleared by resume
    t_simid simid_q;      // Packets accepted so far
    t_simid simid_nxt;

    // Nuke wins over a same-cycle mispredict
    assign redirect    = nuke_rb1.valid | br_mispred_ex0.valid;
    assign redirect_pc = nuke_rb1.valid ? nuke_rb1.pc : br_mispred_ex0.target;

    assign issue  = !halted_q && !redirect && (fb_fe_rsp_nnn.free_credit != '0);
    assign accept = valid_fe1 && !stall;

    // Register empty or draining, and not on a redirect edge
    assign load = fb_fe_rsp_nnn.head_valid && (!valid_fe1 || !stall) && !redirect;

    // A packet loaded while fe1 leaves gets the following number
    assign simid_nxt = simid_q + t_simid'(accept);

    always_comb begin
        fe_fb_req_nnn.valid = issue;
        fe_fb_req_nnn.pc    = pc_q;
        fe_fb_req_nnn.epoch = epoch_q;
        fe_fb_req_nnn.flush = redirect;   // One-cycle pulse per redirect
    end

    // PC, epoch and halt control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q     <= reset_pc;
            epoch_q  <= '0;
            halted_q <= 1'b0;
        end else begin
            if (redirect) begin
                pc_q    <= redirect_pc;
                epoch_q <= epoch_q + t_epoch'(1);   // Old path now stale
            end else if (issue) begin
                pc_q <= pc_q + t_pc'(4);             // Sequential fetch
            end

            if (nuke_rb1.valid)
                halted_q <= 1'b1;
            else if (resume_fetch_rbx)
                halted_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            simid_q <= '0;
        else
            simid_q <= simid_nxt;
    end

    // fe1 valid, cleared on redirect even under stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            valid_fe1 <= 1'b0;
        else if (redirect)
            valid_fe1 <= 1'b0;
        else if (load)
            valid_fe1 <= 1'b1;
        else if (accept)
            valid_fe1 <= 1'b0;
    end

    // fe1 payload
    always_ff @(posedge clk) begin
        if (load) begin
            instr_fe1 <= '{pc:    fb_fe_rsp_nnn.head_pc,
                           instr: fb_fe_rsp_nnn.head_instr,
                           simid: simid_nxt};
        end
    end

    // Held packet must not change under back-pressure
    a_fe1_hold: assert property (@(posedge clk) disable iff (!arst_n)
        valid_fe1 && stall |=> $stable(instr_fe1));

    // While halted nothing is fetched and nothing reaches decode
    a_halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        halted_q |-> !fe_fb_req_nnn.valid && !valid_fe1);

endmodule

// ==== source/fetch.sv ====
`timescale 1ns/1ns

module fetch
    import fetch_pkg::*;
#(
    parameter t_pc reset_pc = '0,
    parameter int  fb_depth = 4
) (
    input  logic            clk,
    input  logic            arst_n,

    output t_mem_req_pkt    fb_ic_req_nnn,
    input  t_mem_rsp_pkt    ic_fb_rsp_nnn,

    input  t_br_mispred_pkt br_mispred_ex0,
    input  t_nuke_pkt       nuke_rb1,
    input  logic            resume_fetch_rbx,

    input  logic            decode_ready_de0,
    output logic            valid_fe1,
    output t_instr_pkt      instr_fe1
);

    t_fe_fb_req fe_fb_req_nnn;
    t_fb_fe_rsp fb_fe_rsp_nnn;
    logic       stall;
    logic       pop;

    assign stall = ~decode_ready_de0;

    // Same decision as the fe1 load inside fe_ctl
    assign pop = fb_fe_rsp_nnn.head_valid && (!valid_fe1 || !stall) && !fe_fb_req_nnn.flush;

    fe_ctl #(
        .reset_pc ( reset_pc )
    ) fe_ctl (
        .clk,
        .arst_n,
        .nuke_rb1,
        .resume_fetch_rbx,
        .br_mispred_ex0,
        .fe_fb_req_nnn,
        .fb_fe_rsp_nnn,
        .stall,
        .valid_fe1,
        .instr_fe1
    );

    fe_buf #(
        .fb_depth ( fb_depth )
    ) fe_buf (
        .clk,
        .arst_n,
        .fe_fb_req_fb0 ( fe_fb_req_nnn ),
        .fb_fe_rsp_nnn,
        .pop,
        .fb_ic_req_nnn,
        .ic_fb_rsp_nnn
    );

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top
    import fetch_pkg::*;
#(
    parameter t_pc reset_pc    = 32'h0000_01c0,   // Word 112, wraps soon
    parameter int  fb_depth    = 4,
    parameter int  rom_words   = 128,
    parameter int  rom_latency = 2
) (
    input  logic            clk,
    input  logic            arst_n,
    input  t_br_mispred_pkt br_mispred_ex0,
    input  t_nuke_pkt       nuke_rb1,
    input  logic            resume_fetch_rbx,
    input  logic            decode_ready_de0,
    output logic            valid_fe1,
    output t_instr_pkt      instr_fe1,
    input  logic            load_en,
    input  t_pc             load_addr,
    input  t_rv_instr       load_data
);

    t_mem_req_pkt fb_ic_req_nnn;
    t_mem_rsp_pkt ic_fb_rsp_nnn;

    fetch #(
        .reset_pc ( reset_pc ),
        .fb_depth ( fb_depth )
    ) fetch (
        .clk,
        .arst_n,
        .fb_ic_req_nnn,
        .ic_fb_rsp_nnn,
        .br_mispred_ex0,
        .nuke_rb1,
        .resume_fetch_rbx,
        .decode_ready_de0,
        .valid_fe1,
        .instr_fe1
    );

    instr_rom #(
        .rom_words   ( rom_words ),
        .rom_latency ( rom_latency )
    ) instr_rom (
        .clk,
        .arst_n,
        .req ( fb_ic_req_nnn ),
        .rsp ( ic_fb_rsp_nnn ),
        .load_en,
        .load_addr,
        .load_data
    );

endmodule

// ==== sim/tb_fetch.sv ====
`timescale 1ns/1ns

module tb_fetch
    import fetch_pkg::*;
();

    localparam t_pc reset_pc    = 32'h0000_01c0;   // Word 112, stream wraps at word 128
    localparam int  fb_depth    = 4;
    localparam int  rom_words   = 128;
    localparam int  rom_latency = 2;
    localparam int  idx_w       = $clog2(rom_words);

    logic            clk;
    logic            arst_n;
    t_br_mispred_pkt br_mispred_ex0;
    t_nuke_pkt       nuke_rb1;
    logic            resume_fetch_rbx;
    logic            decode_ready_de0;
    logic            valid_fe1;
    t_instr_pkt      instr_fe1;
    logic            load_en;
    t_pc             load_addr;
    t_rv_instr       load_data;

    t_rv_instr  shadow [rom_words];   // Copy of every loaded word
    integer     seed;
    t_pc        exp_pc;               // Reference PC of the next accepted packet
    t_simid     exp_simid;
    int         n_accepted;
    int         errors;
    int         tests_passed;
    int         tests_failed;
    logic       held_valid;           // Packet stalled at the last edge
    t_instr_pkt held_pkt;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    fetch_top #(
        .reset_pc    ( reset_pc ),
        .fb_depth    ( fb_depth ),
        .rom_words   ( rom_words ),
        .rom_latency ( rom_latency )
    ) uut (
        .clk,
        .arst_n,
        .br_mispred_ex0,
        .nuke_rb1,
        .resume_fetch_rbx,
        .decode_ready_de0,
        .valid_fe1,
        .instr_fe1,
        .load_en,
        .load_addr,
        .load_data
    );

    // Random program, one word per cycle
    task automatic load_rom();
        int rnd;
        for (int i = 0; i < rom_words; i++) begin
            rnd       = $random(seed);
            load_en   = 1'b1;
            load_addr = t_pc'(i) << 2;
            load_data = t_rv_instr'(rnd);
            shadow[idx_w'(i)] = t_rv_instr'(rnd);
            @(posedge clk);
            #1;
        end
        load_en = 1'b0;
    endtask

    // Compare the packet decode takes now against the model
    task automatic check_packet();
        t_rv_instr exp_instr;
        exp_instr = shadow[idx_w'(exp_pc >> 2)];   // Index wraps mod rom_words
        assert (instr_fe1.pc == exp_pc) else begin
            $display("Fail at %0t: pc %h, expected %h", $time, instr_fe1.pc, exp_pc);
            errors++;
        end
        assert (instr_fe1.instr == exp_instr) else begin
            $display("Fail at %0t: instr %h at pc %h, expected %h",
                     $time, instr_fe1.instr, instr_fe1.pc, exp_instr);
            errors++;
        end
        assert (instr_fe1.simid == exp_simid) else begin
            $display("Fail at %0t: simid %0d, expected %0d", $time, instr_fe1.simid, exp_simid);
            errors++;
        end
        exp_pc    = exp_pc + 32'd4;
        exp_simid = exp_simid + 16'd1;
        n_accepted++;
    endtask

    // One clock: sample outputs, update model, advance, drop strobes
    task automatic tick();
        logic redirect;
        redirect = nuke_rb1.valid || br_mispred_ex0.valid;
        if (held_valid) begin
            assert (valid_fe1 && instr_fe1 == held_pkt) else begin
                $display("Fail at %0t: stalled packet changed, pc %h was %h",
                         $time, instr_fe1.pc, held_pkt.pc);
                errors++;
            end
        end
        if (valid_fe1 && decode_ready_de0)
            check_packet();                    // Old-path packet may still go on this edge
        held_valid = valid_fe1 && !decode_ready_de0 && !redirect;
        held_pkt   = instr_fe1;
        if (nuke_rb1.valid)
            exp_pc = nuke_rb1.pc;              // Nuke wins
        else if (br_mispred_ex0.valid)
            exp_pc = br_mispred_ex0.target;
        @(posedge clk);
        #1;
        nuke_rb1         = '0;
        br_mispred_ex0   = '0;
        resume_fetch_rbx = 1'b0;
    endtask

    task automatic wait_accepts(input int n, input int limit, input bit rand_ready);
        int target;
        int cycles;
        int rnd;
        target = n_accepted + n;
        cycles = 0;
        while (n_accepted < target && cycles < limit) begin
            if (rand_ready) begin
                rnd              = $random(seed);
                decode_ready_de0 = rnd[0];
            end
            tick();
            cycles++;
        end
        if (n_accepted < target) begin
            $display("Timeout: only %0d of %0d packets were accepted in %0d cycles",
                     n_accepted - target + n, n, limit);
            errors++;
        end
    endtask

    task automatic await_valid(input int limit);
        int cycles;
        cycles = 0;
        while (!valid_fe1 && cycles < limit) begin
            tick();
            cycles++;
        end
        if (!valid_fe1) begin
            $display("Timeout: no packet reached decode within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    task automatic sequential_fetch();
        int err_start;
        err_start        = errors;
        decode_ready_de0 = 1'b1;
        wait_accepts(40, 200, 1'b0);           // Crosses word 127 to word 0
        report("sequential fetch", err_start);
    endtask

    task automatic back_pressure();
        int err_start;
        err_start = errors;
        wait_accepts(40, 400, 1'b1);
        decode_ready_de0 = 1'b1;
        report("back-pressure", err_start);
    endtask

    task automatic branch_mispredict();
        int err_start;
        int rnd;
        err_start        = errors;
        decode_ready_de0 = 1'b1;
        wait_accepts(5, 100, 1'b0);
        rnd                   = $random(seed);
        br_mispred_ex0.valid  = 1'b1;
        br_mispred_ex0.target = t_pc'(rnd) & 32'hffff_fffc;
        tick();
        wait_accepts(20, 200, 1'b0);           // Target first, then sequential
        report("branch mispredict", err_start);
    endtask

    task automatic nuke_and_resume();
        int err_start;
        int rnd;
        err_start        = errors;
        decode_ready_de0 = 1'b1;
        wait_accepts(5, 100, 1'b0);
        rnd            = $random(seed);
        nuke_rb1.valid = 1'b1;
        nuke_rb1.pc    = t_pc'(rnd) & 32'hffff_fffc;
        tick();
        repeat (20) begin
            assert (!valid_fe1) else begin
                $display("Fail at %0t: valid_fe1 high while fetch is halted", $time);
                errors++;
            end
            tick();
        end
        resume_fetch_rbx = 1'b1;
        tick();
        wait_accepts(20, 200, 1'b0);           // simid carries on from before the nuke
        report("nuke and resume", err_start);
    endtask

    task automatic redirect_under_stall();
        int err_start;
        int rnd;
        err_start        = errors;
        decode_ready_de0 = 1'b0;
        await_valid(50);
        repeat (10) tick();                    // Queue fills behind the held packet
        rnd                   = $random(seed);
        br_mispred_ex0.valid  = 1'b1;
        br_mispred_ex0.target = t_pc'(rnd) & 32'hffff_fffc;
        tick();
        decode_ready_de0 = 1'b1;
        wait_accepts(20, 200, 1'b0);
        report("redirect under stall", err_start);
    endtask

    initial begin
        seed             = 32'h8602dad2;
        arst_n           = 1'b0;
        load_en          = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        br_mispred_ex0   = '0;
        nuke_rb1         = '0;
        resume_fetch_rbx = 1'b0;
        decode_ready_de0 = 1'b0;
        exp_pc           = reset_pc;
        exp_simid        = '0;
        n_accepted       = 0;
        errors           = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        held_valid       = 1'b0;
        held_pkt         = '0;

        @(posedge clk);
        #1;
        load_rom();                            // Stage idle in reset meanwhile
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        sequential_fetch();
        back_pressure();
        branch_mispredict();
        nuke_and_resume();
        redirect_under_stall();

        $display("Tests passed: %0d, failed: %0d, checks failed: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
source/fetch_pkg.sv
source/instr_rom.sv
source/fe_buf.sv
source/fe_ctl.sv
source/fetch.sv
source/fetch_top.sv
sim/tb_fetch.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_fetch -f compile.f -o Vtb_fetch

run: build
	./obj_dir/Vtb_fetch | tee $(LOG)
	@grep -q "Test OK" $(LOG) && ! grep -q "Test FAILED" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall --top-module tb_fetch -f compile.f

clean:
	rm -rf obj_dir $(LOG)
